// File: bench/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
  input logic                              clk,
  input logic                              rst,
  input logic                              insn_valid,
  input logic [rv_isa_pkg::XLEN-1:0]       pc,
  input logic                              halt,
  input logic                              retire_valid,
  input logic                              retire_rd_we,
  input logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd
);

  // One retire per accepted strobe, one cycle later
  retire_follows_strobe: assert property (@(posedge clk) disable iff (rst)
    retire_valid == $past(insn_valid && !halt))
    else $error("retire_valid does not follow an accepted strobe by one cycle");

  pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  rd_we_nonzero: assert property (@(posedge clk) disable iff (rst)
    retire_rd_we |-> retire_rd != '0)
    else $error("register write reported for x0");

  no_retire_when_halted: assert property (@(posedge clk) disable iff (rst)
    halt |=> !retire_valid)
    else $error("instruction retired while the core was halted");

endmodule

bind rv_core rv_core_checker u_checker (
  .clk, .rst, .insn_valid, .pc, .halt, .retire_valid, .retire_rd_we, .retire_rd
);

// File: bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int N_INSNS    = 300;
  localparam int N_AFTER    = 8; // Strobes after the halt, and again after reset
  localparam int MAX_CYCLES = 2 * (N_INSNS + 2 * N_AFTER + 1) + 40;

  // Expected result of one strobe
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] npc;
    logic        ill;
    logic        hlt;
  } retire_t;

  logic        clk, rst, insn_valid;
  logic [31:0] insn, pc, retire_data;
  logic        halt, retire_valid, retire_rd_we, retire_illegal;
  logic [4:0]  retire_rd;

  logic [31:0] shadow [32];
  logic [31:0] model_pc;
  logic        model_halt;
  logic        strobe_seen = 1'b0;
  retire_t     exp_q [$];
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  rv_core UUT (
    .clk, .rst, .insn_valid, .insn, .pc, .halt, .retire_valid,
    .retire_rd_we, .retire_rd, .retire_data, .retire_illegal
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  alu_ref = alt ? x - y : x + y;
      3'b001:  alu_ref = x << y[4:0];
      3'b010:  alu_ref = {31'd0, $signed(x) < $signed(y)};
      3'b011:  alu_ref = {31'd0, x < y};
      3'b100:  alu_ref = x ^ y;
      3'b101:  alu_ref = alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  alu_ref = x | y;
      default: alu_ref = x & y;
    endcase
  endfunction

  // Architectural effect of one instruction
  function automatic retire_t ref_step(input logic [31:0] ins, input logic [31:0] cur_pc,
                                       input logic [31:0] regs [32]);
    retire_t     e;
    logic [31:0] a, b, imm_i, imm_b, imm_j, imm_u, val;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        taken;
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    f3    = ins[14:12];
    f7    = ins[31:25];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'd0};
    e       = '0;
    e.valid = 1'b1;
    e.rd    = ins[11:7];
    e.npc   = cur_pc + 32'd4;
    val     = cur_pc + 32'd4; // Link value unless replaced
    taken   = 1'b0;
    case (ins[6:0])
      7'h37: val = imm_u;
      7'h17: val = cur_pc + imm_u;
      7'h6f: e.npc = cur_pc + imm_j;
      7'h67: begin
        e.ill = (f3 != 3'b000);
        e.npc = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: e.ill = 1'b1;
        endcase
        if (taken) e.npc = cur_pc + imm_b;
      end
      7'h13: begin
        e.ill = (f3 == 3'b001 && f7 != 7'h00) ||
                (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        val   = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
      end
      7'h33: begin
        e.ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        val   = alu_ref(f3, f7[5], a, b);
      end
      7'h73: begin
        e.hlt = (ins[31:7] == 25'd0); // ECALL
        e.ill = !e.hlt;
      end
      default: e.ill = 1'b1;
    endcase
    if (e.ill) e.npc = cur_pc + 32'd4;
    e.we   = !e.ill && ins[6:0] != 7'h63 && ins[6:0] != 7'h73 && e.rd != 5'd0;
    e.data = val;
    return e;
  endfunction

  function automatic logic [31:0] make_insn(input logic [31:0] regs [32]);
    logic [31:0] r, s, off, t, ins;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    int unsigned kind;
    r    = $urandom();
    s    = $urandom();
    kind = $urandom_range(0, 10);
    rd   = (s[12:10] == 3'd0) ? 5'd0 : r[11:7]; // Extra weight on x0
    rs1  = r[19:15];
    rs2  = r[24:20];
    f3   = r[14:12];
    off  = {{26{s[9]}}, s[9:6], 2'b00}; // Small word offset
    case (kind)
      0, 1, 2: begin
        if (f3 == 3'b001) ins = {7'd0, r[24:20], rs1, f3, rd, 7'h13};
        else if (f3 == 3'b101) ins = {1'b0, s[0], 5'd0, r[24:20], rs1, f3, rd, 7'h13};
        else ins = {r[31:20], rs1, f3, rd, 7'h13};
      end
      3, 4: ins = {1'b0, s[0] && (f3 == 3'b000 || f3 == 3'b101), 5'd0, rs2, rs1, f3, rd, 7'h33};
      5: ins = {r[31:12], rd, 7'h37};
      6: ins = {r[31:12], rd, 7'h17};
      7: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1; // Skip the two unused conditions
        ins = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
      end
      8: ins = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
      9: begin
        // Target lands on a word, bit 0 sometimes set
        t   = $urandom_range(0, 31) * 4 - 64 + ((32'd4 - regs[rs1]) & 32'd3) + {31'd0, s[0]};
        ins = {t[11:0], rs1, 3'b000, rd, 7'h67};
      end
      default: begin
        case (s[1:0])
          2'd0:    ins = {r[31:7], 7'h03}; // Load
          2'd1:    ins = {r[31:7], 7'h0f}; // Fence
          2'd2:    ins = {7'h01, rs2, rs1, f3, rd, 7'h33};
          default: ins = {r[31:15], 3'b010, r[11:7], 7'h63};
        endcase
      end
    endcase
    return ins;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic apply_reset();
    rst        <= 1'b1;
    insn_valid <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    model_pc   = 32'd0;
    model_halt = 1'b0;
  endtask

  // Strobe one instruction, sometimes after an idle cycle
  task automatic issue(input logic [31:0] ins);
    retire_t e;
    if ($urandom_range(0, 2) == 0) begin
      insn_valid <= 1'b0;
      @(posedge clk);
    end
    if (model_halt) begin
      e     = '0;
      e.npc = model_pc;
      e.hlt = 1'b1;
    end else begin
      e = ref_step(ins, model_pc, shadow);
      if (e.we) shadow[e.rd] = e.data;
      model_pc   = e.npc;
      model_halt = e.hlt;
    end
    exp_q.push_back(e);
    insn_valid <= 1'b1;
    insn       <= ins;
    @(posedge clk);
  endtask

  task automatic drain();
    insn_valid <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Retire outputs are settled by the falling edge
  always @(negedge clk) begin
    retire_t e;
    if (strobe_seen) begin
      e = exp_q.pop_front();
      check_value("retire_valid", 32'(retire_valid), 32'(e.valid));
      check_value("pc", pc, e.npc);
      check_value("halt", 32'(halt), 32'(e.hlt));
      if (e.valid) begin
        check_value("retire_illegal", 32'(retire_illegal), 32'(e.ill));
        check_value("retire_rd_we", 32'(retire_rd_we), 32'(e.we));
      end
      if (e.we) begin
        check_value("retire_rd", 32'(retire_rd), 32'(e.rd));
        check_value("retire_data", retire_data, e.data);
      end
    end
    strobe_seen = insn_valid && !rst;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc1bf));
    rst        = 1'b1;
    insn_valid = 1'b0;
    insn       = '0;
    apply_reset();
    for (int i = 0; i < N_INSNS; i++) issue(make_insn(shadow));
    issue(32'h0000_0073); // ECALL
    for (int i = 0; i < N_AFTER; i++) issue(make_insn(shadow));
    drain();
    apply_reset();
    @(negedge clk);
    check_value("pc", pc, 32'd0);
    check_value("halt", 32'(halt), 32'd0);
    @(posedge clk);
    for (int i = 0; i < N_AFTER; i++) issue(make_insn(shadow));
    drain();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: flist.f
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/insn_decoder.sv
source/reg_file.sv
source/int_alu.sv
source/next_pc_unit.sv
source/retire_stage.sv
source/rv_core.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_core_tb -f flist.f -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: source/core_ctrl_pkg.sv
package core_ctrl_pkg;

  // Operation performed by the integer ALU
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // LUI
  } alu_op_e;

  typedef enum logic {src_a_rs1, src_a_pc} src_a_e;

  typedef enum logic {src_b_rs2, src_b_imm} src_b_e;

  // How the next pc is formed
  typedef enum logic [1:0] {flow_seq, flow_branch, flow_jal, flow_jalr} flow_e;

  // Register writeback source
  typedef enum logic [1:0] {wb_none, wb_alu, wb_link} wb_sel_e;

endpackage

// File: source/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  logic [rv_isa_pkg::XLEN-1:0]       insn,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr,
  output logic [rv_isa_pkg::XLEN-1:0]       imm,
  output core_ctrl_pkg::alu_op_e            alu_op,
  output core_ctrl_pkg::src_a_e             src_a,
  output core_ctrl_pkg::src_b_e             src_b,
  output core_ctrl_pkg::flow_e              flow,
  output logic [2:0]                        branch_cond,
  output core_ctrl_pkg::wb_sel_e            wb_sel,
  output logic                              halt_req,
  output logic                              illegal
);

  rv_isa_pkg::opcode_e               opcode;
  logic [2:0]                        funct3;
  logic [6:0]                        funct7;
  logic                              f7_zero;
  logic                              f7_alt;
  logic [rv_isa_pkg::XLEN-1:0]       imm_i, imm_b, imm_j, imm_u;

  // funct3 to ALU op, alt picks sub or sra
  function automatic core_ctrl_pkg::alu_op_e funct_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: funct_to_op = alt ? core_ctrl_pkg::alu_sub : core_ctrl_pkg::alu_add;
      rv_isa_pkg::F3_SLL:     funct_to_op = core_ctrl_pkg::alu_sll;
      rv_isa_pkg::F3_SLT:     funct_to_op = core_ctrl_pkg::alu_slt;
      rv_isa_pkg::F3_SLTU:    funct_to_op = core_ctrl_pkg::alu_sltu;
      rv_isa_pkg::F3_XOR:     funct_to_op = core_ctrl_pkg::alu_xor;
      rv_isa_pkg::F3_SRL_SRA: funct_to_op = alt ? core_ctrl_pkg::alu_sra : core_ctrl_pkg::alu_srl;
      rv_isa_pkg::F3_OR:      funct_to_op = core_ctrl_pkg::alu_or;
      default:                funct_to_op = core_ctrl_pkg::alu_and;
    endcase
  endfunction

  assign opcode      = rv_isa_pkg::opcode_e'(insn[6:0]);
  assign funct3      = insn[14:12];
  assign funct7      = insn[31:25];
  assign f7_zero     = (funct7 == 7'd0);
  assign f7_alt      = (funct7 == rv_isa_pkg::FUNCT7_ALT);
  assign rd_addr     = insn[11:7];
  assign rs1_addr    = insn[19:15];
  assign rs2_addr    = insn[24:20];
  assign branch_cond = funct3;

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  always_comb begin
    alu_op   = core_ctrl_pkg::alu_add;
    src_a    = core_ctrl_pkg::src_a_rs1;
    src_b    = core_ctrl_pkg::src_b_rs2;
    flow     = core_ctrl_pkg::flow_seq;
    wb_sel   = core_ctrl_pkg::wb_none;
    imm      = imm_i;
    halt_req = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        alu_op = core_ctrl_pkg::alu_pass_b;
        src_b  = core_ctrl_pkg::src_b_imm;
        imm    = imm_u;
        wb_sel = core_ctrl_pkg::wb_alu;
      end
      rv_isa_pkg::op_auipc: begin
        src_a  = core_ctrl_pkg::src_a_pc; // pc + U immediate
        src_b  = core_ctrl_pkg::src_b_imm;
        imm    = imm_u;
        wb_sel = core_ctrl_pkg::wb_alu;
      end
      rv_isa_pkg::op_jal: begin
        imm    = imm_j;
        flow   = core_ctrl_pkg::flow_jal;
        wb_sel = core_ctrl_pkg::wb_link;
      end
      rv_isa_pkg::op_jalr: begin
        flow    = core_ctrl_pkg::flow_jalr;
        wb_sel  = core_ctrl_pkg::wb_link;
        illegal = (funct3 != 3'b000);
      end
      rv_isa_pkg::op_branch: begin
        imm     = imm_b;
        flow    = core_ctrl_pkg::flow_branch;
        illegal = (funct3 == 3'b010) || (funct3 == 3'b011); // No condition there
      end
      rv_isa_pkg::op_reg_imm: begin
        src_b   = core_ctrl_pkg::src_b_imm;
        wb_sel  = core_ctrl_pkg::wb_alu;
        alu_op  = funct_to_op(funct3, (funct3 == rv_isa_pkg::F3_SRL_SRA) && f7_alt);
        // Shift amounts share bits with funct7
        illegal = ((funct3 == rv_isa_pkg::F3_SLL) && !f7_zero) ||
                  ((funct3 == rv_isa_pkg::F3_SRL_SRA) && !(f7_zero || f7_alt));
      end
      rv_isa_pkg::op_reg_reg: begin
        wb_sel  = core_ctrl_pkg::wb_alu;
        alu_op  = funct_to_op(funct3, f7_alt);
        illegal = !(f7_zero || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                           funct3 == rv_isa_pkg::F3_SRL_SRA)));
      end
      rv_isa_pkg::op_system: begin
        halt_req = (insn[31:7] == 25'd0); // ECALL only
        illegal  = !halt_req;
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      wb_sel = core_ctrl_pkg::wb_none;
      flow   = core_ctrl_pkg::flow_seq;
    end
  end

endmodule

// File: source/int_alu.sv
`timescale 1ns/1ps

module int_alu (
  input  core_ctrl_pkg::alu_op_e      alu_op,
  input  core_ctrl_pkg::src_a_e       src_a,
  input  core_ctrl_pkg::src_b_e       src_b,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] pc,
  input  logic [rv_isa_pkg::XLEN-1:0] imm,
  output logic [rv_isa_pkg::XLEN-1:0] result
);

  logic [rv_isa_pkg::XLEN-1:0] op_a;
  logic [rv_isa_pkg::XLEN-1:0] op_b;
  logic [4:0]                  shamt;

  // Operand muxes
  assign op_a  = (src_a == core_ctrl_pkg::src_a_pc) ? pc : rs1_data;
  assign op_b  = (src_b == core_ctrl_pkg::src_b_imm) ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::alu_add:  result = op_a + op_b;
      core_ctrl_pkg::alu_sub:  result = op_a - op_b;
      core_ctrl_pkg::alu_sll:  result = op_a << shamt;
      core_ctrl_pkg::alu_slt: begin
        result = {{(rv_isa_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      core_ctrl_pkg::alu_sltu: begin
        result = {{(rv_isa_pkg::XLEN-1){1'b0}}, op_a < op_b};
      end
      core_ctrl_pkg::alu_xor:  result = op_a ^ op_b;
      core_ctrl_pkg::alu_srl:  result = op_a >> shamt;
      core_ctrl_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> shamt); // Sign fill
      core_ctrl_pkg::alu_or:   result = op_a | op_b;
      core_ctrl_pkg::alu_and:  result = op_a & op_b;
      core_ctrl_pkg::alu_pass_b: result = op_b;
      default:                 result = op_a + op_b;
    endcase
  end

endmodule

// File: source/next_pc_unit.sv
`timescale 1ns/1ps

module next_pc_unit (
  input  core_ctrl_pkg::flow_e        flow,
  input  logic [2:0]                  branch_cond,
  input  logic [rv_isa_pkg::XLEN-1:0] pc,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] imm,
  output logic [rv_isa_pkg::XLEN-1:0] next_pc,
  output logic [rv_isa_pkg::XLEN-1:0] link_addr
);

  logic                        taken;
  logic [rv_isa_pkg::XLEN-1:0] seq_pc;
  logic [rv_isa_pkg::XLEN-1:0] rel_target;
  logic [rv_isa_pkg::XLEN-1:0] jalr_sum;

  assign seq_pc     = pc + rv_isa_pkg::PC_STEP;
  assign rel_target = pc + imm; // Branch and JAL target
  assign jalr_sum   = rs1_data + imm;
  assign link_addr  = seq_pc;

  // Branch condition
  always_comb begin
    case (branch_cond)
      rv_isa_pkg::F3_BEQ:  taken = (rs1_data == rs2_data);
      rv_isa_pkg::F3_BNE:  taken = (rs1_data != rs2_data);
      rv_isa_pkg::F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_isa_pkg::F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_isa_pkg::F3_BLTU: taken = (rs1_data < rs2_data);
      rv_isa_pkg::F3_BGEU: taken = (rs1_data >= rs2_data);
      default:             taken = 1'b0;
    endcase
  end

  always_comb begin
    case (flow)
      core_ctrl_pkg::flow_branch: next_pc = taken ? rel_target : seq_pc;
      core_ctrl_pkg::flow_jal:    next_pc = rel_target;
      // JALR drops bit 0 of the sum
      core_ctrl_pkg::flow_jalr:   next_pc = {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0};
      default:                    next_pc = seq_pc;
    endcase
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
  input  logic                              we,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wa,
  input  logic [rv_isa_pkg::XLEN-1:0]       wd
);

  // x0 has no storage
  logic [rv_isa_pkg::XLEN-1:0] regs [1:rv_isa_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Asynchronous reads
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: source/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              insn_valid,
  input  core_ctrl_pkg::wb_sel_e            wb_sel,
  input  logic                              illegal,
  input  logic                              halt_req,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]       alu_result,
  input  logic [rv_isa_pkg::XLEN-1:0]       link_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]       next_pc,
  output logic                              rf_we,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_wa,
  output logic [rv_isa_pkg::XLEN-1:0]       rf_wd,
  output logic [rv_isa_pkg::XLEN-1:0]       pc,
  output logic                              halt,
  output logic                              retire_valid,
  output logic                              retire_rd_we,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_data,
  output logic                              retire_illegal
);

  logic accept; // Strobe taken this cycle

  assign accept = insn_valid && !halt;
  assign rf_wa  = rd_addr;
  assign rf_we  = accept && (wb_sel != core_ctrl_pkg::wb_none) && (rd_addr != '0);

  always_comb begin
    case (wb_sel)
      core_ctrl_pkg::wb_alu:  rf_wd = alu_result;
      core_ctrl_pkg::wb_link: rf_wd = link_addr;
      default:                rf_wd = '0;
    endcase
  end

  // Pc, halt and retire flags
  always_ff @(posedge clk) begin
    if (rst) begin
      pc             <= rv_isa_pkg::RESET_PC;
      halt           <= 1'b0;
      retire_valid   <= 1'b0;
      retire_rd_we   <= 1'b0;
      retire_illegal <= 1'b0;
    end else begin
      retire_valid   <= accept;
      retire_rd_we   <= rf_we;
      retire_illegal <= accept && illegal;
      if (accept) begin
        pc <= next_pc;
        if (halt_req) halt <= 1'b1; // Sticky until reset
      end
    end
  end

  // Retire payload
  always_ff @(posedge clk) begin
    if (accept) begin
      retire_rd   <= rd_addr;
      retire_data <= rf_wd;
    end
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              insn_valid,
  input  logic [rv_isa_pkg::XLEN-1:0]       insn,
  output logic [rv_isa_pkg::XLEN-1:0]       pc,
  output logic                              halt,
  output logic                              retire_valid,
  output logic                              retire_rd_we,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_data,
  output logic                              retire_illegal
);

  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr, rf_wa;
  logic [rv_isa_pkg::XLEN-1:0]       imm, rs1_data, rs2_data, rf_wd;
  logic [rv_isa_pkg::XLEN-1:0]       alu_result, next_pc, link_addr;
  core_ctrl_pkg::alu_op_e            alu_op;
  core_ctrl_pkg::src_a_e             src_a;
  core_ctrl_pkg::src_b_e             src_b;
  core_ctrl_pkg::flow_e              flow;
  core_ctrl_pkg::wb_sel_e            wb_sel;
  logic [2:0]                        branch_cond;
  logic                              halt_req, illegal, rf_we;

  insn_decoder u_dec (
    .insn, .rs1_addr, .rs2_addr, .rd_addr, .imm, .alu_op, .src_a, .src_b,
    .flow, .branch_cond, .wb_sel, .halt_req, .illegal
  );

  reg_file u_rf (
    .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .we(rf_we), .wa(rf_wa), .wd(rf_wd)
  );

  // ALU and next-pc work side by side
  int_alu u_alu (
    .alu_op, .src_a, .src_b, .rs1_data, .rs2_data, .pc, .imm, .result(alu_result)
  );

  next_pc_unit u_npc (
    .flow, .branch_cond, .pc, .rs1_data, .rs2_data, .imm, .next_pc, .link_addr
  );

  retire_stage u_ret (
    .clk, .rst, .insn_valid, .wb_sel, .illegal, .halt_req, .rd_addr,
    .alu_result, .link_addr, .next_pc, .rf_we, .rf_wa, .rf_wd, .pc, .halt,
    .retire_valid, .retire_rd_we, .retire_rd, .retire_data, .retire_illegal
  );

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

  // Datapath and register file geometry
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;
  localparam logic [XLEN-1:0] RESET_PC = 32'd0;

  // Major opcodes that the core understands
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011
  } opcode_e;

  // Selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU functions, same codes for immediate and register forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage
